// File: run.sh
#!/bin/sh
# run from the project root so tests/rom.hex is found
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_fetch_top -f sim.f -o tb_fetch_top \
  && ./obj_dir/tb_fetch_top > sim.log 2>&1 \
  || { echo "compile or run error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: sim.f
verilog/fetch_pkg.sv
verilog/fetch_unit.sv
verilog/inst_rom_axi.sv
verilog/if_id_reg.sv
verilog/fetch_top.sv
tests/tb_clock_gen.sv
tests/tb_fetch_top.sv

// File: tests/rom.hex
// one 64-bit word per line, word 0 at RESET_PC; upper 32 bits hold the instruction at word address + 4
0020011300100093
0040021300300193
0060031300500293
0080041300700393
00a0051300900493
00c0061300b00593
00e0071300d00693
0100081300f00793
0120091301100893
01400a1301300993
01600b1301500a93
01800c1301700b93
01a00d1301900c93
01c00e1301b00d93
01e00f1301d00e93
0200009301f00f93

// File: tests/tb_clock_gen.sv
// free-running clock with no enable; the first rising edge comes half a period after time zero
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_fetch_top.sv
// run from the project root so the rom image path resolves; rst_n asserts high and is synchronous
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top
  import fetch_pkg::*;
();

  // about 220 deliveries of four to seven cycles each stay well below the limit
  localparam int MAX_CYCLES        = 4000;
  localparam int DELIVERY_LIMIT    = 64;
  localparam int RANDOM_DELIVERIES = 200;
  localparam int ROM_BYTES         = ROM_WORDS * 8;

  logic  clk;
  logic  rst_n;
  logic  redirect;
  addr_t redirect_pc;
  logic  stall;
  logic  id_valid;
  addr_t id_pc;
  inst_t id_inst;
  logic  fetch_err;

  dword_t image [ROM_WORDS];
  addr_t  exp_pc;
  int     test_errors;
  int     tests_passed;
  int     tests_failed;
  int     cycle_count;

  tb_clock_gen #(.PERIOD_NS(100)) u_clock_gen (.clk_o(clk));

  fetch_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .stall_i       (stall),
    .id_valid_o    (id_valid),
    .id_pc_o       (id_pc),
    .id_inst_o     (id_inst),
    .fetch_err_o   (fetch_err)
  );

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a test did not finish", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // =========================================================================
  // reference model and checks
  // =========================================================================
  // outside the window the memory answers with zero data
  function automatic inst_t expected_inst(addr_t pc);
    addr_t  offset;
    dword_t word;
    offset = pc - RESET_PC;
    if (offset >= addr_t'(ROM_BYTES)) begin
      return '0;
    end
    word = image[offset[ROM_AW+2:3]];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic check_addr(string sig, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", sig, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_inst(string sig, inst_t got, inst_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", sig, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_bit(string sig, logic got, logic exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", sig, got, exp);
      test_errors++;
    end
  endtask

  // outputs are sampled and inputs driven 10 ns after each rising edge
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  // a valid if/id entry counts as new only when the edge was not stalled
  task automatic wait_delivery(output logic found);
    int waited;
    found = 1'b0;
    waited = 0;
    while (!found && waited < DELIVERY_LIMIT) begin
      step();
      waited++;
      if (id_valid && !stall) begin
        found = 1'b1;
      end
    end
    if (!found) begin
      $display("no instruction delivered within %0d cycles", DELIVERY_LIMIT);
      test_errors++;
    end
  endtask

  task automatic check_delivery();
    logic found;
    wait_delivery(found);
    if (found) begin
      check_addr("id_pc_o", id_pc, exp_pc);
      check_inst("id_inst_o", id_inst, expected_inst(exp_pc));
    end
    exp_pc = exp_pc + addr_t'(4);
  endtask

  task automatic send_redirect(addr_t target);
    redirect = 1'b1;
    redirect_pc = target;
    exp_pc = target;
    step();
    redirect = 1'b0;
  endtask

  task automatic finish_test(int num, string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, test_errors);
    end
    test_errors = 0;
  endtask

  // =========================================================================
  // directed tests
  // =========================================================================
  task automatic test_sequential();
    repeat (8) begin
      check_delivery();
      check_bit("fetch_err_o", fetch_err, 1'b0);
    end
  endtask

  task automatic test_stall();
    addr_t held_pc;
    inst_t held_inst;
    check_delivery();
    held_pc = id_pc;
    held_inst = id_inst;
    stall = 1'b1;
    repeat (6) begin
      step();
      check_bit("id_valid_o", id_valid, 1'b1);
      check_addr("id_pc_o", id_pc, held_pc);
      check_inst("id_inst_o", id_inst, held_inst);
    end
    stall = 1'b0;
    repeat (4) check_delivery();
  endtask

  task automatic test_redirect();
    // stall holds the last entry while the next read is in flight
    stall = 1'b1;
    step();
    step();
    check_bit("id_valid_o", id_valid, 1'b1);
    send_redirect(RESET_PC + 64'h24);
    check_bit("id_valid_o", id_valid, 1'b0);
    stall = 1'b0;
    repeat (4) check_delivery();
  endtask

  task automatic test_bad_target();
    send_redirect(RESET_PC + 64'h1000);
    repeat (2) begin
      check_delivery();
      check_bit("fetch_err_o", fetch_err, 1'b1);
    end
    send_redirect(RESET_PC);
    check_delivery();
    check_bit("fetch_err_o", fetch_err, 1'b1);
  endtask

  task automatic test_random();
    int   delivered;
    logic was_redirect;
    delivered = 0;
    was_redirect = 1'b0;
    while (delivered < RANDOM_DELIVERIES) begin
      step();
      if (id_valid && !stall) begin
        check_addr("id_pc_o", id_pc, exp_pc);
        check_inst("id_inst_o", id_inst, expected_inst(exp_pc));
        exp_pc = exp_pc + addr_t'(4);
        delivered++;
      end
      redirect = 1'b0;
      stall = ($urandom % 4) == 0;
      // also jump back before the stream runs off the end of the image
      if (!was_redirect &&
          (exp_pc >= RESET_PC + addr_t'(ROM_BYTES) || ($urandom % 16) == 0)) begin
        redirect = 1'b1;
        redirect_pc = RESET_PC + addr_t'(($urandom % (ROM_WORDS * 2)) * 4);
        exp_pc = redirect_pc;
      end
      was_redirect = redirect;
    end
    stall = 1'b0;
    redirect = 1'b0;
    check_bit("fetch_err_o", fetch_err, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h40cc2d1d));
    $readmemh(ROM_FILE, image);
    rst_n = 1'b1;
    redirect = 1'b0;
    redirect_pc = RESET_PC;
    stall = 1'b0;
    exp_pc = RESET_PC;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count = 0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b0;

    test_sequential();
    finish_test(1, "sequential fetch");
    test_stall();
    finish_test(2, "stall hold");
    test_redirect();
    finish_test(3, "redirect");
    test_bad_target();
    finish_test(4, "out of window fetch");
    test_random();
    finish_test(5, "random stalls and redirects");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/fetch_pkg.sv
// widths, reset address and rom image path shared by the fetch stage; rom path is relative to the run directory
`default_nettype none

package fetch_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int XLEN = 64;
  localparam int ILEN = 32;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] dword_t;
  typedef logic [ILEN-1:0] inst_t;
  typedef logic [1:0]      resp_t;

  // ==========================================================================
  // memory map and image
  // ==========================================================================
  localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

  // 16 dwords of 8 bytes, 128 bytes from RESET_PC
  localparam int ROM_WORDS = 16;
  localparam int ROM_AW    = 4;

  localparam string ROM_FILE = "tests/rom.hex";

  // read response codes, same values as the AXI bus
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // fetch request fsm
  typedef enum logic [0:0] {
    IDLE      = 1'b0,
    WAIT_DATA = 1'b1
  } fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/fetch_top.sv
// fetch stage top; rom uses the default two wait states, one instruction per four cycles when not stalled
`timescale 1ns/1ns
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  redirect_i,
  input  wire addr_t redirect_pc_i,
  input  wire logic  stall_i,
  output logic       id_valid_o,
  output addr_t      id_pc_o,
  output inst_t      id_inst_o,
  output logic       fetch_err_o
);

  // read address channel
  logic  arvalid;
  logic  arready;
  addr_t araddr;

  // read data channel
  logic   rvalid;
  logic   rready;
  dword_t rdata;
  resp_t  rresp;

  // fetch to if/id
  logic  fire;
  addr_t fire_pc;
  inst_t fire_inst;

  fetch_unit u_fetch_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .arready_i     (arready),
    .rvalid_i      (rvalid),
    .rdata_i       (rdata),
    .rresp_i       (rresp),
    .arvalid_o     (arvalid),
    .rready_o      (rready),
    .araddr_o      (araddr),
    .fire_o        (fire),
    .fire_pc_o     (fire_pc),
    .fire_inst_o   (fire_inst),
    .fetch_err_o   (fetch_err_o)
  );

  inst_rom_axi #(
    .RD_LATENCY (2)
  ) u_inst_rom_axi (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid_i (arvalid),
    .araddr_i  (araddr),
    .rready_i  (rready),
    .stall_i   (stall_i),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  // redirect flushes the stage in the same edge
  if_id_reg u_if_id_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .fire_i  (fire),
    .pc_i    (fire_pc),
    .inst_i  (fire_inst),
    .stall_i (stall_i),
    .flush_i (redirect_i),
    .valid_o (id_valid_o),
    .pc_o    (id_pc_o),
    .inst_o  (id_inst_o)
  );

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
// one read outstanding at a time; rst_n is active high and sync; araddr follows the pc register
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  redirect_i,
  input  wire addr_t redirect_pc_i,
  input  wire logic  stall_i,
  input  wire logic  arready_i,
  input  wire logic  rvalid_i,
  input  wire dword_t rdata_i,
  input  wire resp_t rresp_i,
  output logic       arvalid_o,
  output logic       rready_o,
  output addr_t      araddr_o,
  output logic       fire_o,
  output addr_t      fire_pc_o,
  output inst_t      fire_inst_o,
  output logic       fetch_err_o
);

  fetch_state_t state_q;
  fetch_state_t state_d;

  addr_t pc_q;
  logic  kill_q;
  logic  err_q;

  logic  ar_hs;
  logic  consume;

  // ==========================================================================
  // channel handshakes
  // ==========================================================================
  assign arvalid_o = (state_q == IDLE);
  assign rready_o  = (state_q == WAIT_DATA);
  assign araddr_o  = pc_q;

  assign ar_hs = arvalid_o && arready_i;

  // stall keeps rready up but leaves the beat with the slave
  assign consume = rvalid_i && rready_o && !stall_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (ar_hs) begin
          state_d = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (consume) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==========================================================================
  // pc and kill flag
  // ==========================================================================
  // redirect wins over the +4 step
  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (consume && !kill_q) begin
      pc_q <= pc_q + addr_t'(4);
    end
  end

  // a read already issued with the old pc must not reach decode
  always_ff @(posedge clk) begin
    if (rst_n) begin
      kill_q <= 1'b0;
    end else if (redirect_i && !consume && (rready_o || ar_hs)) begin
      kill_q <= 1'b1;
    end else if (consume) begin
      kill_q <= 1'b0;
    end
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst_n) begin
      err_q <= 1'b0;
    end else if (consume && (rresp_i != RESP_OKAY)) begin
      err_q <= 1'b1;
    end
  end

  // ==========================================================================
  // fetch output
  // ==========================================================================
  // same-cycle redirect also drops the beat
  assign fire_o      = consume && !kill_q && !redirect_i;
  assign fire_pc_o   = pc_q;
  assign fire_inst_o = pc_q[2] ? rdata_i[63:32] : rdata_i[31:0];
  assign fetch_err_o = err_q;

endmodule

`default_nettype wire

// File: verilog/if_id_reg.sv
// flush beats capture, stall beats everything else; pc and inst hold no reset value, only valid does
`timescale 1ns/1ns
`default_nettype none

module if_id_reg
  import fetch_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  fire_i,
  input  wire addr_t pc_i,
  input  wire inst_t inst_i,
  input  wire logic  stall_i,
  input  wire logic  flush_i,
  output logic       valid_o,
  output addr_t      pc_o,
  output inst_t      inst_o
);

  logic  valid_q;
  addr_t pc_q;
  inst_t inst_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      // a bubble when no fetch completed
      valid_q <= fire_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fire_i && !stall_i && !flush_i) begin
      pc_q   <= pc_i;
      inst_q <= inst_i;
    end
  end

  assign valid_o = valid_q;
  assign pc_o    = pc_q;
  assign inst_o  = inst_q;

endmodule

`default_nettype wire

// File: verilog/inst_rom_axi.sv
// read-only, single beat, one read at a time; RD_LATENCY must be at least 1; image loaded from ROM_FILE
`timescale 1ns/1ns
`default_nettype none

module inst_rom_axi
  import fetch_pkg::*;
#(
  parameter int RD_LATENCY = 2
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  arvalid_i,
  input  wire addr_t araddr_i,
  input  wire logic  rready_i,
  input  wire logic  stall_i,
  output logic       arready_o,
  output logic       rvalid_o,
  output dword_t     rdata_o,
  output resp_t      rresp_o
);

  localparam int CNT_W = $clog2(RD_LATENCY + 1);

  dword_t mem [ROM_WORDS];

  logic             busy_q;
  logic             rvalid_q;
  logic [CNT_W-1:0] cnt_q;
  dword_t           rdata_q;
  resp_t            rresp_q;

  addr_t             offset;
  logic              in_range;
  logic [ROM_AW-1:0] word_idx;
  logic              ar_hs;
  logic              r_hs;

  initial begin
    $readmemh(ROM_FILE, mem);
  end

  // ==========================================================================
  // address decode
  // ==========================================================================
  // below RESET_PC wraps to a huge offset and falls out too
  assign offset   = araddr_i - RESET_PC;
  assign in_range = (offset[XLEN-1:ROM_AW+3] == '0);
  assign word_idx = araddr_i[ROM_AW+2:3];

  assign arready_o = !busy_q;
  assign ar_hs     = arvalid_i && arready_o;

  // beat is held while the fetch side is stalled
  assign r_hs = rvalid_q && rready_i && !stall_i;

  // ==========================================================================
  // wait states and response hold
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      busy_q   <= 1'b0;
      rvalid_q <= 1'b0;
      cnt_q    <= '0;
    end else if (ar_hs) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(RD_LATENCY);
    end else if (r_hs) begin
      busy_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - CNT_W'(1);
      // last wait state
      if (cnt_q == CNT_W'(1)) begin
        rvalid_q <= 1'b1;
      end
    end
  end

  // data and response latched at address acceptance
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      if (in_range) begin
        rdata_q <= mem[word_idx];
        rresp_q <= RESP_OKAY;
      end else begin
        rdata_q <= '0;
        rresp_q <= RESP_SLVERR;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

endmodule

`default_nettype wire
